/* loudness_monitor.f */
+incdir+source
source/monitor_pkg.sv
source/bus_pkg.sv
source/monitor_regs.sv
source/loudness_detector.sv
source/json_formatter.sv
source/uart_tx.sv
source/loudness_monitor_top.sv
dv/loudness_monitor_assertions.sv
dv/loudness_monitor_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the loudness monitor testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module loudness_monitor_tb -f loudness_monitor.f
out=$(./obj_dir/Vloudness_monitor_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

/* dv/loudness_monitor_tb.sv */
`timescale 1ns/10ps
`include "monitor_cfg.svh"

module loudness_monitor_tb import monitor_pkg::*, bus_pkg::*; ();

    localparam int hs_limit   = 50;          // Cycles per handshake wait
    localparam int uart_limit = 3000;        // Cycles to a start bit

    logic       CLOCK_50;
    logic       rst;
    logic [7:0] loudness;
    logic       start;
    axil_req_t  s_axi_req;
    axil_rsp_t  s_axi_rsp;
    logic       tx;
    level_t     level;
    logic       stop_detect;
    logic       busy;

    int     err_cnt;
    int     chk_cnt;
    int     baud_div;                        // Mirror of BAUD register
    integer seed;

    loudness_monitor_top u_loudness_monitor_top (
        .CLOCK_50    (CLOCK_50),
        .rst         (rst),
        .loudness    (loudness),
        .start       (start),
        .s_axi_req   (s_axi_req),
        .s_axi_rsp   (s_axi_rsp),
        .tx          (tx),
        .level       (level),
        .stop_detect (stop_detect),
        .busy        (busy)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;    // 100 ns period
    end

    task automatic check_level(input level_t got, input level_t exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    // Count of thresholds strictly exceeded
    function automatic level_t expected_level(input logic [7:0] s, input logic [31:0] thr);
        logic [2:0] n;
        n = 3'd0;
        for (int i = 0; i < 4; i++) begin
            if (s > thr[8*i +: 8]) n = n + 3'd1;
        end
        return level_t'(n);
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        s_axi_req.awvalid = 1'b1;
        s_axi_req.awaddr  = addr;
        s_axi_req.wvalid  = 1'b1;
        s_axi_req.wdata   = data;
        s_axi_req.wstrb   = strb;
        n = 0;
        while (!(s_axi_rsp.awready && s_axi_rsp.wready) && n < hs_limit) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        if (!(s_axi_rsp.awready && s_axi_rsp.wready)) begin
            err_cnt++;
            $display("Timeout at %0t ns: slave never raised awready and wready", $time);
        end
        @(posedge CLOCK_50);                 // Address and data taken here
        #1;
        s_axi_req.awvalid = 1'b0;
        s_axi_req.wvalid  = 1'b0;
        s_axi_req.bready  = 1'b1;
        n = 0;
        while (!s_axi_rsp.bvalid && n < hs_limit) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        if (!s_axi_rsp.bvalid) begin
            err_cnt++;
            $display("Timeout at %0t ns: no write response from slave", $time);
        end
        resp = s_axi_rsp.bresp;
        @(posedge CLOCK_50);                 // Response taken
        #1;
        s_axi_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        s_axi_req.arvalid = 1'b1;
        s_axi_req.araddr  = addr;
        n = 0;
        while (!s_axi_rsp.arready && n < hs_limit) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        if (!s_axi_rsp.arready) begin
            err_cnt++;
            $display("Timeout at %0t ns: slave never raised arready", $time);
        end
        @(posedge CLOCK_50);
        #1;
        s_axi_req.arvalid = 1'b0;
        s_axi_req.rready  = 1'b1;
        n = 0;
        while (!s_axi_rsp.rvalid && n < hs_limit) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        if (!s_axi_rsp.rvalid) begin
            err_cnt++;
            $display("Timeout at %0t ns: no read data from slave", $time);
        end
        data = s_axi_rsp.rdata;
        resp = s_axi_rsp.rresp;
        @(posedge CLOCK_50);
        #1;
        s_axi_req.rready = 1'b0;
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        logic [1:0] r;
        axi_write(addr, data, 4'hf, r);
        check_resp(r, 2'b00, "write response");
    endtask

    task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
        logic [1:0] r;
        axi_read(addr, data, r);
        check_resp(r, 2'b00, "read response");
    endtask

    task automatic expect_reg(input logic [31:0] addr, input logic [31:0] exp, input string msg);
        logic [31:0] d;
        reg_read(addr, d);
        check_data(d, exp, msg);
    endtask

    task automatic drive_samples(input logic [7:0] v, input int n);
        repeat (n) begin
            loudness = v;
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    task automatic uart_get_byte(output logic [7:0] b, output logic ok);
        int n;
        int i;
        b = 8'd0;
        n = 0;
        while (tx && n < uart_limit) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        ok = !tx;
        if (!ok) begin
            err_cnt++;
            $display("Timeout at %0t ns: no UART start bit seen", $time);
        end else begin
            repeat (baud_div / 2) @(posedge CLOCK_50);   // Middle of start bit
            #1;
            check_byte({7'd0, tx}, 8'd0, "start bit");
            for (i = 0; i < 8; i++) begin
                repeat (baud_div) @(posedge CLOCK_50);
                #1;
                b[i] = tx;                              // LSB first
            end
            repeat (baud_div) @(posedge CLOCK_50);
            #1;
            check_byte({7'd0, tx}, 8'd1, "stop bit");
        end
    endtask

    task automatic report_result(input string name, input int e0);
        if (err_cnt == e0) begin
            $display("[%0t ns] test %s: ok", $time, name);
        end else begin
            $display("[%0t ns] test %s: %0d mismatches", $time, name, err_cnt - e0);
        end
    endtask

    task automatic register_access();
        int          e0;
        logic [31:0] d;
        logic [1:0]  r;
        e0 = err_cnt;
        expect_reg(`MON_ADDR_CTRL, 32'd1, "CTRL reset");
        expect_reg(`MON_ADDR_THRESH, `MON_THRESH_RST, "THRESH reset");
        expect_reg(`MON_ADDR_HOLD, {16'd0, `MON_HOLD_RST}, "HOLD reset");
        expect_reg(`MON_ADDR_BAUD, {16'd0, `MON_BAUD_RST}, "BAUD reset");
        expect_reg(`MON_ADDR_STATUS, 32'd0, "STATUS reset");
        reg_write(`MON_ADDR_THRESH, 32'hc864_3219);
        expect_reg(`MON_ADDR_THRESH, 32'hc864_3219, "THRESH readback");
        axi_write(`MON_ADDR_THRESH, 32'h0102_0304, 4'b0101, r);   // Bytes 0 and 2 only
        check_resp(r, 2'b00, "strobed write response");
        expect_reg(`MON_ADDR_THRESH, 32'hc802_3204, "THRESH byte strobes");
        reg_write(`MON_ADDR_HOLD, 32'h0000_1234);
        expect_reg(`MON_ADDR_HOLD, 32'h0000_1234, "HOLD readback");
        reg_write(`MON_ADDR_BAUD, 32'h0000_00c8);
        baud_div = 200;
        expect_reg(`MON_ADDR_BAUD, 32'h0000_00c8, "BAUD readback");
        axi_write(32'h0000_0020, 32'h0000_0000, 4'hf, r);         // Would clear enable if aliased
        check_resp(r, 2'b10, "unmapped write");
        axi_read(32'h0000_0020, d, r);
        check_resp(r, 2'b10, "unmapped read");
        expect_reg(`MON_ADDR_CTRL, 32'd1, "CTRL after unmapped write");
        report_result("registers", e0);
    endtask

    task automatic level_sweep();
        int          e0;
        logic [31:0] rnd;
        logic [31:0] d;
        level_t      exp;
        e0 = err_cnt;
        reg_write(`MON_ADDR_THRESH, 32'h281e_140a);            // 10, 20, 30, 40
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            drive_samples(rnd[7:0] % 8'd50, 1);                // Spans all five levels
            exp = expected_level(loudness, 32'h281e_140a);
            check_level(level, exp, "level output");
            reg_read(`MON_ADDR_STATUS, d);
            check_data(d & 32'h7, {29'd0, exp}, "STATUS level");
        end
        report_result("levels", e0);
    endtask

    task automatic stop_latch();
        int          e0;
        logic [31:0] d;
        e0 = err_cnt;
        loudness = 8'd0;
        reg_write(`MON_ADDR_HOLD, 32'd5);
        reg_write(`MON_ADDR_CTRL, 32'h3);                     // Enable and clear
        drive_samples(8'd200, 4);
        drive_samples(8'd0, 3);                               // Run broken
        check_data({31'd0, stop_detect}, 32'd0, "stop after four peaks");
        drive_samples(8'd200, 4);
        check_data({31'd0, stop_detect}, 32'd0, "stop before fifth peak");
        drive_samples(8'd200, 1);
        check_data({31'd0, stop_detect}, 32'd1, "stop after fifth peak");
        drive_samples(8'd0, 5);
        check_data({31'd0, stop_detect}, 32'd1, "stop latched");
        reg_read(`MON_ADDR_STATUS, d);
        check_data(d & 32'h8, 32'h8, "STATUS stop bit");
        reg_write(`MON_ADDR_CTRL, 32'h3);
        drive_samples(8'd0, 1);
        check_data({31'd0, stop_detect}, 32'd0, "stop after clear");
        report_result("stop", e0);
    endtask

    task automatic json_message();
        int         e0;
        int         n;
        int         lows;
        int         i;
        string      msg;
        logic [7:0] b;
        logic       ok;
        level_t     lvl;
        e0 = err_cnt;
        reg_write(`MON_ADDR_THRESH, 32'h281e_1405);            // 5, 20, 30, 40
        reg_write(`MON_ADDR_BAUD, 32'd4);
        baud_div = 4;
        drive_samples(8'd7, 3);
        lvl = expected_level(8'd7, 32'h281e_1405);
        check_level(level, normal, "level before start");
        msg = $sformatf("{\"lvl\":%03d,\"st\":%0d}\n", 7, int'(lvl));
        start = 1'b1;
        @(posedge CLOCK_50);
        #1;
        start = 1'b0;
        check_data({31'd0, busy}, 32'd1, "busy after start");
        for (i = 0; i < `MON_MSG_LEN; i++) begin
            uart_get_byte(b, ok);
            if (ok) check_byte(b, msg[i], $sformatf("message byte %0d", i));
            if (i == 5) begin                                  // Edge while busy
                start = 1'b1;
                @(posedge CLOCK_50);
                #1;
                start = 1'b0;
            end
        end
        n = 0;
        while (busy && n < hs_limit) begin
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        check_data({31'd0, busy}, 32'd0, "busy after message");
        lows = 0;
        repeat (100) begin
            @(posedge CLOCK_50);
            #1;
            if (!tx) lows++;
        end
        check_data(lows, 32'd0, "line quiet after message");
        report_result("message", e0);
    endtask

    task automatic enable_gate();
        int e0;
        e0 = err_cnt;
        loudness = 8'd0;
        reg_write(`MON_ADDR_THRESH, 32'h281e_140a);
        reg_write(`MON_ADDR_CTRL, 32'd0);
        for (int k = 0; k < 10; k++) begin
            drive_samples(8'd200, 1);
            check_level(level, quiet, "level while disabled");
        end
        check_data({31'd0, stop_detect}, 32'd0, "stop while disabled");
        loudness = 8'd0;
        reg_write(`MON_ADDR_CTRL, 32'd1);
        drive_samples(8'd25, 1);
        check_level(level, expected_level(8'd25, 32'h281e_140a), "level enabled again");
        drive_samples(8'd200, 1);
        check_level(level, expected_level(8'd200, 32'h281e_140a), "peak enabled again");
        drive_samples(8'd0, 1);
        report_result("enable", e0);
    endtask

    initial begin
        seed      = 32'hab88;
        err_cnt   = 0;
        chk_cnt   = 0;
        baud_div  = int'(`MON_BAUD_RST);
        rst       = 1'b1;
        loudness  = 8'd0;
        start     = 1'b0;
        s_axi_req = '0;
        repeat (5) @(posedge CLOCK_50);
        #1;
        rst = 1'b0;
        @(posedge CLOCK_50);
        #1;
        register_access();
        level_sweep();
        stop_latch();
        json_message();
        enable_gate();
        $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* dv/loudness_monitor_assertions.sv */
`timescale 1ns/10ps

module loudness_monitor_assertions import monitor_pkg::*, bus_pkg::*; (
    input logic      CLOCK_50,
    input logic      rst,
    input axil_req_t s_axi_req,
    input axil_rsp_t s_axi_rsp,
    input logic      tx,
    input logic      busy,
    input level_t    level
);

    // Write response held until the master takes it
    a_bvalid_hold: assert property (@(posedge CLOCK_50) disable iff (rst)
        s_axi_rsp.bvalid && !s_axi_req.bready |=> s_axi_rsp.bvalid)
        else $error("bvalid dropped before bready");

    a_tx_idle: assert property (@(posedge CLOCK_50) disable iff (rst)
        !busy |-> tx)                                // No frame outside a message
        else $error("tx low while formatter idle");

    a_level_range: assert property (@(posedge CLOCK_50) disable iff (rst)
        level <= peak)
        else $error("level above peak");

endmodule

bind loudness_monitor_top loudness_monitor_assertions u_loudness_monitor_assertions (
    .CLOCK_50  (CLOCK_50),
    .rst       (rst),
    .s_axi_req (s_axi_req),
    .s_axi_rsp (s_axi_rsp),
    .tx        (tx),
    .busy      (busy),
    .level     (level)
);

/* source/loudness_monitor_top.sv */
`timescale 1ns/10ps

module loudness_monitor_top import monitor_pkg::*, bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       rst,
    input  logic [7:0] loudness,
    input  logic       start,
    input  axil_req_t  s_axi_req,
    output axil_rsp_t  s_axi_rsp,
    output logic       tx,
    output level_t     level,
    output logic       stop_detect,
    output logic       busy
);

    det_cfg_t    det_cfg;
    det_status_t det_status;
    uart_cfg_t   uart_cfg;
    byte_beat_t  beat;               // Formatter to serializer
    logic        uart_ready;
    logic        line_idle;

    monitor_regs u_monitor_regs (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .s_axi_req  (s_axi_req),
        .s_axi_rsp  (s_axi_rsp),
        .det_status (det_status),
        .busy       (busy),
        .det_cfg    (det_cfg),
        .uart_cfg   (uart_cfg)
    );

    loudness_detector u_loudness_detector (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .loudness   (loudness),
        .det_cfg    (det_cfg),
        .det_status (det_status)
    );

    json_formatter u_json_formatter (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .start      (start),
        .loudness   (loudness),
        .det_status (det_status),
        .uart_ready (uart_ready),
        .line_idle  (line_idle),
        .beat       (beat),
        .busy       (busy)
    );

    uart_tx u_uart_tx (
        .CLOCK_50   (CLOCK_50),
        .rst        (rst),
        .beat       (beat),
        .uart_cfg   (uart_cfg),
        .ready      (uart_ready),
        .tx         (tx),
        .line_idle  (line_idle)
    );

    assign level       = det_status.level;
    assign stop_detect = det_status.stop;

endmodule

/* source/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx import bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       rst,
    input  byte_beat_t beat,
    input  uart_cfg_t  uart_cfg,
    output logic       ready,
    output logic       tx,
    output logic       line_idle
);

    logic        active;             // Frame in flight
    logic [8:0]  shift;              // Data bits then stop
    logic [3:0]  bit_cnt;
    logic [15:0] div_cnt;            // Clocks into current bit
    logic        last_q;

    always_ff @(posedge CLOCK_50 or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            ready     <= 1'b0;
            tx        <= 1'b1;
            bit_cnt   <= 4'd0;
            div_cnt   <= 16'd0;
            line_idle <= 1'b0;
            last_q    <= 1'b0;
        end else if (!active) begin
            ready <= 1'b1;
            if (ready && beat.valid) begin
                active    <= 1'b1;
                ready     <= 1'b0;
                tx        <= 1'b0;                   // Start bit
                bit_cnt   <= 4'd0;
                div_cnt   <= 16'd0;
                last_q    <= beat.last;
                line_idle <= 1'b0;
            end
        end else if (div_cnt == uart_cfg.baud_div - 16'd1) begin
            div_cnt <= 16'd0;
            if (bit_cnt == 4'd9) begin               // Stop bit done
                active    <= 1'b0;
                ready     <= 1'b1;
                line_idle <= last_q;
            end else begin
                tx      <= shift[0];                 // LSB first
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            div_cnt <= div_cnt + 16'd1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!active && ready && beat.valid) begin
            shift <= {1'b1, beat.data};
        end else if (active && div_cnt == uart_cfg.baud_div - 16'd1) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

/* source/json_formatter.sv */
`timescale 1ns/10ps
`include "monitor_cfg.svh"

module json_formatter import monitor_pkg::*, bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        rst,
    input  logic        start,
    input  logic [7:0]  loudness,
    input  det_status_t det_status,
    input  logic        uart_ready,
    input  logic        line_idle,
    output byte_beat_t  beat,
    output logic        busy
);

    typedef enum logic [1:0] {st_idle, st_conv, st_send, st_wait} fmt_state_t;

    fmt_state_t state;
    logic       start_d;
    logic       start_edge;
    logic [7:0] lo_q;                // Aligned with det_status.level
    logic [7:0] rem;                 // Leaves the ones digit
    logic [3:0] hund;
    logic [3:0] tens;
    level_t     lvl_cap;
    logic [4:0] idx;                 // Byte position in message
    logic [7:0] ch;

    assign start_edge = start && !start_d;

    always_ff @(posedge CLOCK_50) begin
        lo_q <= loudness;
    end

    always_ff @(posedge CLOCK_50 or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            start_d <= 1'b0;
            busy    <= 1'b0;
            rem     <= 8'd0;
            hund    <= 4'd0;
            tens    <= 4'd0;
            lvl_cap <= quiet;
            idx     <= 5'd0;
        end else begin
            start_d <= start;
            case (state)
                st_idle: begin
                    if (start_edge) begin             // Edges while busy never reach here
                        state   <= st_conv;
                        busy    <= 1'b1;
                        rem     <= lo_q;
                        lvl_cap <= det_status.level;
                        hund    <= 4'd0;
                        tens    <= 4'd0;
                    end
                end
                st_conv: begin                        // Compare-subtract
                    if (rem >= 8'd100) begin
                        rem  <= rem - 8'd100;
                        hund <= hund + 4'd1;
                    end else if (rem >= 8'd10) begin
                        rem  <= rem - 8'd10;
                        tens <= tens + 4'd1;
                    end else begin
                        state <= st_send;
                        idx   <= 5'd0;
                    end
                end
                st_send: begin
                    if (uart_ready) begin
                        if (beat.last) state <= st_wait;
                        else idx <= idx + 5'd1;
                    end
                end
                st_wait: begin                        // Last stop bit still going
                    if (line_idle) begin
                        state <= st_idle;
                        busy  <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Message {"lvl":DDD,"st":D} plus newline
    always_comb begin
        case (idx)
            5'd0:    ch = 8'h7b;                      // {
            5'd1:    ch = 8'h22;                      // "
            5'd2:    ch = "l";
            5'd3:    ch = "v";
            5'd4:    ch = "l";
            5'd5:    ch = 8'h22;
            5'd6:    ch = ":";
            5'd7:    ch = 8'h30 + {4'd0, hund};
            5'd8:    ch = 8'h30 + {4'd0, tens};
            5'd9:    ch = 8'h30 + {4'd0, rem[3:0]};
            5'd10:   ch = ",";
            5'd11:   ch = 8'h22;
            5'd12:   ch = "s";
            5'd13:   ch = "t";
            5'd14:   ch = 8'h22;
            5'd15:   ch = ":";
            5'd16:   ch = 8'h30 + {5'd0, lvl_cap};
            5'd17:   ch = 8'h7d;                      // }
            default: ch = 8'h0a;                      // Newline
        endcase
    end

    assign beat.valid = (state == st_send);
    assign beat.data  = ch;
    assign beat.last  = (idx == 5'(`MON_MSG_LEN - 1));

endmodule

/* source/loudness_detector.sv */
`timescale 1ns/10ps

module loudness_detector import monitor_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        rst,
    input  logic [7:0]  loudness,
    input  det_cfg_t    det_cfg,
    output det_status_t det_status
);

    logic [2:0]  above;              // Thresholds strictly exceeded
    logic        peak_now;
    logic [15:0] run_cnt;            // Consecutive peak samples
    logic [16:0] run_nxt;

    always_comb begin
        above = 3'd0;
        for (int i = 0; i < 4; i++) begin
            if (loudness > det_cfg.thresh[i]) above = above + 3'd1;
        end
    end

    assign peak_now = det_cfg.enable && (above == 3'd4);
    assign run_nxt  = {1'b0, run_cnt} + 17'd1;

    always_ff @(posedge CLOCK_50 or posedge rst) begin
        if (rst) begin
            det_status.level <= quiet;
            det_status.stop  <= 1'b0;
            run_cnt          <= 16'd0;
        end else begin
            det_status.level <= det_cfg.enable ? level_t'(above) : quiet;
            // Run counter restarts on any non-peak or when disabled
            if (!peak_now) begin
                run_cnt <= 16'd0;
            end else if (run_cnt != 16'hffff) begin
                run_cnt <= run_nxt[15:0];         // Saturates
            end
            // Clear wins over set on the stop latch
            if (det_cfg.stop_clr) begin
                det_status.stop <= 1'b0;
            end else if (peak_now && run_nxt >= {1'b0, det_cfg.hold}) begin
                det_status.stop <= 1'b1;
            end
        end
    end

endmodule

/* source/monitor_regs.sv */
`timescale 1ns/10ps
`include "monitor_cfg.svh"

module monitor_regs import monitor_pkg::*, bus_pkg::*; (
    input  logic        CLOCK_50,
    input  logic        rst,
    input  axil_req_t   s_axi_req,
    output axil_rsp_t   s_axi_rsp,
    input  det_status_t det_status,
    input  logic        busy,
    output det_cfg_t    det_cfg,
    output uart_cfg_t   uart_cfg
);

    logic            enable_q;
    logic            stop_clr_q;     // Self-clearing CTRL bit 1
    logic [3:0][7:0] thresh_q;
    logic [15:0]     hold_q;
    logic [15:0]     baud_q;
    logic            aw_rdy;         // Shared awready/wready pulse
    logic            ar_rdy;
    logic            b_vld;
    logic            r_vld;
    logic [1:0]      b_resp;
    logic [1:0]      r_resp;
    logic [31:0]     r_data;
    logic            wr_fire;
    logic            rd_fire;
    logic            wr_hit;
    logic            rd_hit;
    logic [31:0]     rd_mux;

    assign wr_fire = aw_rdy && s_axi_req.awvalid && s_axi_req.wvalid;
    assign rd_fire = ar_rdy && s_axi_req.arvalid;

    assign wr_hit = s_axi_req.awaddr inside {`MON_ADDR_CTRL, `MON_ADDR_THRESH,
        `MON_ADDR_HOLD, `MON_ADDR_BAUD, `MON_ADDR_STATUS};

    always_comb begin
        rd_hit = 1'b1;
        rd_mux = 32'd0;
        case (s_axi_req.araddr)
            `MON_ADDR_CTRL:   rd_mux = {31'd0, enable_q};
            `MON_ADDR_THRESH: rd_mux = thresh_q;
            `MON_ADDR_HOLD:   rd_mux = {16'd0, hold_q};
            `MON_ADDR_BAUD:   rd_mux = {16'd0, baud_q};
            `MON_ADDR_STATUS: rd_mux = {27'd0, busy, det_status.stop, det_status.level};
            default:          rd_hit = 1'b0;   // Unmapped
        endcase
    end

    always_ff @(posedge CLOCK_50 or posedge rst) begin
        if (rst) begin
            enable_q   <= 1'b1;
            stop_clr_q <= 1'b0;
            thresh_q   <= `MON_THRESH_RST;
            hold_q     <= `MON_HOLD_RST;
            baud_q     <= `MON_BAUD_RST;
            aw_rdy     <= 1'b0;
            ar_rdy     <= 1'b0;
            b_vld      <= 1'b0;
            r_vld      <= 1'b0;
        end else begin
            stop_clr_q <= 1'b0;                   // Pulse lasts one cycle
            // Write channel with one outstanding
            aw_rdy <= s_axi_req.awvalid && s_axi_req.wvalid && !aw_rdy && !b_vld;
            if (wr_fire) begin
                b_vld <= 1'b1;
                case (s_axi_req.awaddr)
                    `MON_ADDR_CTRL: begin
                        if (s_axi_req.wstrb[0]) begin
                            enable_q   <= s_axi_req.wdata[0];
                            stop_clr_q <= s_axi_req.wdata[1];
                        end
                    end
                    `MON_ADDR_THRESH: begin
                        for (int i = 0; i < 4; i++) begin
                            if (s_axi_req.wstrb[i]) thresh_q[i] <= s_axi_req.wdata[8*i +: 8];
                        end
                    end
                    `MON_ADDR_HOLD: begin
                        for (int i = 0; i < 2; i++) begin
                            if (s_axi_req.wstrb[i]) hold_q[8*i +: 8] <= s_axi_req.wdata[8*i +: 8];
                        end
                    end
                    `MON_ADDR_BAUD: begin
                        for (int i = 0; i < 2; i++) begin
                            if (s_axi_req.wstrb[i]) baud_q[8*i +: 8] <= s_axi_req.wdata[8*i +: 8];
                        end
                    end
                    default: ;                    // STATUS read-only and rest unmapped
                endcase
            end else if (b_vld && s_axi_req.bready) begin
                b_vld <= 1'b0;
            end
            // Read channel with one outstanding
            ar_rdy <= s_axi_req.arvalid && !ar_rdy && !r_vld;
            if (rd_fire) begin
                r_vld <= 1'b1;
            end else if (r_vld && s_axi_req.rready) begin
                r_vld <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge CLOCK_50) begin
        if (wr_fire) begin
            b_resp <= wr_hit ? 2'b00 : 2'b10;     // OKAY or SLVERR
        end
        if (rd_fire) begin
            r_data <= rd_mux;
            r_resp <= rd_hit ? 2'b00 : 2'b10;
        end
    end

    assign s_axi_rsp.awready = aw_rdy;
    assign s_axi_rsp.wready  = aw_rdy;
    assign s_axi_rsp.bvalid  = b_vld;
    assign s_axi_rsp.bresp   = b_resp;
    assign s_axi_rsp.arready = ar_rdy;
    assign s_axi_rsp.rvalid  = r_vld;
    assign s_axi_rsp.rdata   = r_data;
    assign s_axi_rsp.rresp   = r_resp;

    assign det_cfg.thresh   = thresh_q;
    assign det_cfg.hold     = hold_q;
    assign det_cfg.enable   = enable_q;
    assign det_cfg.stop_clr = stop_clr_q;
    assign uart_cfg.baud_div = baud_q;

endmodule

/* source/bus_pkg.sv */
package bus_pkg;

    // Master to slave
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;              // Final byte of a message
    } byte_beat_t;

    typedef struct packed {
        logic [15:0] baud_div;         // Clocks per bit
    } uart_cfg_t;

endpackage

/* source/monitor_pkg.sv */
package monitor_pkg;

    // Number of thresholds the sample exceeds
    typedef enum logic [2:0] {
        quiet     = 3'd0,
        normal    = 3'd1,
        loud      = 3'd2,
        very_loud = 3'd3,
        peak      = 3'd4
    } level_t;

    typedef struct packed {
        logic [3:0][7:0] thresh;       // Ascending, index 0 lowest
        logic [15:0]     hold;         // Peak run length for stop
        logic            enable;
        logic            stop_clr;     // One-cycle pulse
    } det_cfg_t;

    typedef struct packed {
        level_t level;
        logic   stop;                  // Latched sustained peak
    } det_status_t;

endpackage

/* source/monitor_cfg.svh */
`ifndef MONITOR_CFG_SVH
`define MONITOR_CFG_SVH

// Thresholds 40, 90, 150, 220 packed low byte first
`define MON_THRESH_RST 32'hdc96_5a28
`define MON_HOLD_RST   16'd16          // Peak samples before stop
`define MON_BAUD_RST   16'd434         // Clocks per UART bit

// Register byte addresses
`define MON_ADDR_CTRL   32'h0000_0000
`define MON_ADDR_THRESH 32'h0000_0004
`define MON_ADDR_HOLD   32'h0000_0008
`define MON_ADDR_BAUD   32'h0000_000c
`define MON_ADDR_STATUS 32'h0000_0010

`define MON_MSG_LEN 19                 // JSON line incl. newline

`endif
